// File: stat_counters.f
hdl/stat_pkg.sv
hdl/delay.sv
hdl/sram_bypass.sv
hdl/stat_sram.sv
hdl/stat_arbiter.sv
hdl/stat_update.sv
hdl/stat_host.sv
hdl/stat_counters.sv
bench/tb_stat_counters.sv

// File: Bender.yml
package:
  name: stat_counters

sources:
  - hdl/stat_pkg.sv
  - hdl/delay.sv
  - hdl/sram_bypass.sv
  - hdl/stat_sram.sv
  - hdl/stat_arbiter.sv
  - hdl/stat_update.sv
  - hdl/stat_host.sv
  - hdl/stat_counters.sv
  - target: test
    files:
      - bench/tb_stat_counters.sv

// File: bench/tb_stat_counters.sv
`timescale 1ns/1ps

module tb_stat_counters import stat_pkg::*; ();

  localparam int WAIT_MAX = 2000; // cycles allowed for any single wait

  logic             clk;
  logic             rst_n;
  logic             i_evt_valid;
  evt_t             i_evt;
  logic             i_host_req_valid;
  host_req_t        i_host_req;
  logic             o_host_busy;
  logic             o_host_rsp_valid;
  host_rsp_t        o_host_rsp;
  logic             o_evt_uerr;
  logic [IDX_W-1:0] o_evt_uerr_idx;

  logic [CNT_W-1:0] model [2**IDX_W]; // expected counter values
  logic [31:0]      lfsr_q = 32'h406184dd;
  logic             uerr_expected = 1'b0;
  int               rsp_errs = 0;
  int               idx_errs = 0;
  int               other_errs = 0;

  stat_counters dut0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_evt_valid      (i_evt_valid),
    .i_evt            (i_evt),
    .i_host_req_valid (i_host_req_valid),
    .i_host_req       (i_host_req),
    .o_host_busy      (o_host_busy),
    .o_host_rsp_valid (o_host_rsp_valid),
    .o_host_rsp       (o_host_rsp),
    .o_evt_uerr       (o_evt_uerr),
    .o_evt_uerr_idx   (o_evt_uerr_idx)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  // o_evt_uerr is only legal right after a double-flip clear
  always @(posedge clk) begin
    if (rst_n && (o_evt_uerr !== 1'b0) && !uerr_expected) begin
      $display("ERROR t=%0t o_evt_uerr: got %b, expected 0 (counter %0d)", $time, o_evt_uerr,
               o_evt_uerr_idx);
      other_errs++;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]}; // one step per bit
    end
  endtask

  function automatic logic [CNT_W-1:0] sat_add(input logic [CNT_W-1:0] cnt,
                                               input logic [INC_W-1:0] inc);
    int unsigned total;
    total = cnt + inc;
    if (total > cnt_max) return cnt_max; // clamp at all ones
    return CNT_W'(total);
  endfunction

  task automatic print_counts();
    $display("errors: rsp %0d, uerr_idx %0d, other %0d", rsp_errs, idx_errs, other_errs);
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    other_errs++;
    print_counts();
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic check_rsp(input string what, input host_rsp_t got, input host_rsp_t exp);
    string exp_s;
    if (got !== exp) begin
      exp_s = $sformatf("data=%h cerr=%b uerr=%b", exp.data, exp.cerr, exp.uerr);
      $display("ERROR t=%0t o_host_rsp (%s): got data=%h cerr=%b uerr=%b, expected %s",
               $time, what, got.data, got.cerr, got.uerr, exp_s);
      rsp_errs++;
    end
  endtask

  task automatic check_uerr_idx(input logic [IDX_W-1:0] got, input logic [IDX_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t o_evt_uerr_idx: got %0d, expected %0d", $time, got, exp);
      idx_errs++;
    end
  endtask

  // drives one event for the cycle after this edge and updates the model
  task automatic drive_evt(input logic [IDX_W-1:0] idx, input logic [INC_W-1:0] inc);
    @(posedge clk);
    i_evt_valid <= 1'b1;
    i_evt.idx   <= idx;
    i_evt.inc   <= inc;
    model[idx]  = sat_add(model[idx], inc);
  endtask

  task automatic end_evts();
    @(posedge clk);
    i_evt_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge clk);
    while ((o_host_busy !== 1'b0) && (n < WAIT_MAX)) begin
      @(posedge clk);
      n++;
    end
    if (n >= WAIT_MAX) abort_run("o_host_busy never dropped");
  endtask

  task automatic wait_rsp(output host_rsp_t rsp);
    int n;
    n = 0;
    while ((o_host_rsp_valid !== 1'b1) && (n < WAIT_MAX)) begin
      @(posedge clk);
      n++;
    end
    if (n >= WAIT_MAX) abort_run("no host response pulse");
    rsp = o_host_rsp; // sampled at the edge closing the pulse
  endtask

  task automatic host_op(input host_op_e op, input logic [IDX_W-1:0] idx,
                         input logic [1:0] flip, output host_rsp_t rsp);
    host_req_t req;
    req.op   = op;
    req.idx  = idx;
    req.flip = flip;
    wait_idle();
    i_host_req_valid <= 1'b1;
    i_host_req       <= req;
    @(posedge clk);
    i_host_req_valid <= 1'b0;
    wait_rsp(rsp);
  endtask

  task automatic do_clear(input logic [IDX_W-1:0] idx, input logic [1:0] flip);
    host_rsp_t rsp;
    host_op(HOST_CLEAR, idx, flip, rsp);
    check_rsp("clear", rsp, '0); // clear answers zero without flags
    model[idx] = '0;
  endtask

  task automatic read_check(input string what, input logic [IDX_W-1:0] idx,
                            input host_rsp_t exp);
    host_rsp_t rsp;
    host_op(HOST_READ, idx, 2'b00, rsp);
    check_rsp(what, rsp, exp);
  endtask

  task automatic verify_all(input string what);
    for (int i = 0; i < 2**IDX_W; i++) begin
      read_check(what, IDX_W'(i), host_rsp_t'{data: model[i], cerr: 1'b0, uerr: 1'b0});
    end
  endtask

  task automatic test_clear_all();
    for (int i = 0; i < 2**IDX_W; i++) do_clear(IDX_W'(i), 2'b00);
    verify_all("after clear");
  endtask

  task automatic test_single_events();
    logic [31:0] r_idx;
    logic [31:0] r_inc;
    for (int n = 0; n < 24; n++) begin
      rand_bits(IDX_W, r_idx);
      rand_bits(INC_W, r_inc);
      drive_evt(r_idx[IDX_W-1:0], r_inc[INC_W-1:0]);
      end_evts();
      repeat (3) @(posedge clk); // idle gap so nothing is in flight
    end
    verify_all("single events");
  endtask

  task automatic test_back_to_back();
    logic [31:0] r_idx;
    logic [31:0] r_inc;
    rand_bits(IDX_W, r_idx);
    for (int n = 0; n < 30; n++) begin
      rand_bits(INC_W, r_inc);
      drive_evt(r_idx[IDX_W-1:0], r_inc[INC_W-1:0]); // same counter every cycle
    end
    for (int n = 0; n < 200; n++) begin
      rand_bits(IDX_W, r_idx);
      rand_bits(INC_W, r_inc);
      drive_evt(r_idx[IDX_W-1:0], r_inc[INC_W-1:0]);
    end
    end_evts();
    verify_all("back to back");
  endtask

  task automatic test_saturate();
    do_clear(6'd9, 2'b00);
    for (int n = 0; n < 4368; n++) drive_evt(6'd9, 4'hf); // 65520
    drive_evt(6'd9, 4'hc);
    end_evts();
    read_check("near max", 6'd9, host_rsp_t'{data: cnt_max - 3, cerr: 1'b0, uerr: 1'b0});
    drive_evt(6'd9, 4'h2);
    drive_evt(6'd9, 4'h5);  // crosses the top
    drive_evt(6'd9, 4'h1);
    end_evts();
    read_check("saturated", 6'd9, host_rsp_t'{data: cnt_max, cerr: 1'b0, uerr: 1'b0});
  endtask

  task automatic test_ecc_inject();
    int n;
    do_clear(6'd33, 2'b01);
    read_check("single flip", 6'd33, host_rsp_t'{data: '0, cerr: 1'b1, uerr: 1'b0});
    do_clear(6'd33, 2'b11);
    // two stored data bits inverted and left uncorrected
    read_check("double flip", 6'd33, host_rsp_t'{data: 16'h0003, cerr: 1'b0, uerr: 1'b1});
    uerr_expected = 1'b1;
    drive_evt(6'd33, 4'h6);
    model[33] = 16'h0006;   // uerr read restarts from inc
    end_evts();
    n = 0;
    while ((o_evt_uerr !== 1'b1) && (n < 10)) begin
      @(posedge clk);
      n++;
    end
    if (n >= 10) abort_run("o_evt_uerr never pulsed");
    check_uerr_idx(o_evt_uerr_idx, 6'd33);
    repeat (2) @(posedge clk);
    uerr_expected = 1'b0;
    read_check("after uerr event", 6'd33, host_rsp_t'{data: model[33], cerr: 1'b0, uerr: 1'b0});
  endtask

  task automatic test_host_starved();
    logic [31:0] r_idx;
    logic [31:0] r_inc;
    host_req_t   req;
    host_rsp_t   rsp;
    req.op   = HOST_READ;
    req.idx  = 6'd5;
    req.flip = 2'b00;
    wait_idle();
    for (int i = 0; i < 60; i++) begin
      rand_bits(3, r_idx);    // keep the burst on counters 0..7
      rand_bits(INC_W, r_inc);
      drive_evt(IDX_W'(r_idx[2:0]), r_inc[INC_W-1:0]);
      i_host_req_valid <= (i == 3);
      if (i == 3) i_host_req <= req;
      if ((i >= 5) && (o_host_busy !== 1'b1)) begin
        $display("ERROR t=%0t o_host_busy: got %b, expected 1", $time, o_host_busy);
        other_errs++;
      end
      if (o_host_rsp_valid !== 1'b0) begin
        $display("ERROR t=%0t o_host_rsp_valid: got %b, expected 0", $time, o_host_rsp_valid);
        other_errs++;
      end
    end
    end_evts();
    wait_rsp(rsp);            // granted only once the burst is over
    check_rsp("read during burst", rsp, host_rsp_t'{data: model[5], cerr: 1'b0, uerr: 1'b0});
  endtask

  initial begin
    rst_n            = 1'b0;
    i_evt_valid      = 1'b0;
    i_evt            = '0;
    i_host_req_valid = 1'b0;
    i_host_req       = '0;
    for (int i = 0; i < 2**IDX_W; i++) model[i] = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_clear_all();
    test_single_events();
    test_back_to_back();
    test_saturate();
    test_ecc_inject();
    test_host_starved();
    repeat (4) @(posedge clk);
    print_counts();
    if ((rsp_errs + idx_errs + other_errs) == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/stat_counters.sv
`timescale 1ns/1ps

module stat_counters import stat_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_evt_valid,
  input  evt_t             i_evt,
  input  logic             i_host_req_valid,
  input  host_req_t        i_host_req,
  output logic             o_host_busy,
  output logic             o_host_rsp_valid,
  output host_rsp_t        o_host_rsp,
  output logic             o_evt_uerr,
  output logic [IDX_W-1:0] o_evt_uerr_idx
);

  mem_rd_t          eng_rd;
  mem_wr_t          eng_wr;
  mem_rd_t          host_rd;
  mem_wr_t          host_wr;
  logic             host_rd_gnt;
  logic             host_wr_gnt;
  mem_rd_t          mem_rd;       // winner on the read port
  mem_wr_t          mem_wr;       // winner on the write port
  rd_owner_e        rsp_owner;
  logic [CNT_W-1:0] sram_data;    // decoded array data
  logic             sram_cerr;
  logic             sram_uerr;
  logic [CNT_W-1:0] fwd_data;     // after write forwarding
  logic             fwd_cerr;
  logic             fwd_uerr;

  stat_update u_update (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_evt_valid    (i_evt_valid),
    .i_evt          (i_evt),
    .i_rd_data      (fwd_data),
    .i_uerr         (fwd_uerr),     // cerr data is already corrected
    .i_rsp_owner    (rsp_owner),
    .o_rd           (eng_rd),
    .o_wr           (eng_wr),
    .o_evt_uerr     (o_evt_uerr),
    .o_evt_uerr_idx (o_evt_uerr_idx)
  );

  stat_host u_host (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_req_valid (i_host_req_valid),
    .i_req       (i_host_req),
    .i_rd_gnt    (host_rd_gnt),
    .i_wr_gnt    (host_wr_gnt),
    .i_rd_data   (fwd_data),
    .i_cerr      (fwd_cerr),
    .i_uerr      (fwd_uerr),
    .i_rsp_owner (rsp_owner),
    .o_rd        (host_rd),
    .o_wr        (host_wr),
    .o_busy      (o_host_busy),
    .o_rsp_valid (o_host_rsp_valid),
    .o_rsp       (o_host_rsp)
  );

  stat_arbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_eng_rd      (eng_rd),
    .i_eng_wr      (eng_wr),
    .i_host_rd     (host_rd),
    .i_host_wr     (host_wr),
    .o_host_rd_gnt (host_rd_gnt),
    .o_host_wr_gnt (host_wr_gnt),
    .o_mem_rd      (mem_rd),
    .o_mem_wr      (mem_wr),
    .o_rsp_owner   (rsp_owner)
  );

  stat_sram u_sram (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_rd      (mem_rd),
    .i_wr      (mem_wr),
    .o_rd_data (sram_data),
    .o_cerr    (sram_cerr),
    .o_uerr    (sram_uerr)
  );

  sram_bypass #(
    .WA               (IDX_W),
    .WD               (CNT_W),
    .READ_LATENCY     (RD_LAT),
    .UNFLOPPED_BYPASS (0)
  ) u_bypass (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_sra   (mem_rd.addr),
    .i_srd   (sram_data),
    .i_swa   (mem_wr.addr),
    .i_swen  (mem_wr.en),
    .i_swd   (mem_wr.data),
    .i_suerr (sram_uerr),
    .i_scerr (sram_cerr),
    .o_rd    (fwd_data),
    .o_uerr  (fwd_uerr),
    .o_cerr  (fwd_cerr)
  );

endmodule

// File: hdl/stat_host.sv
`timescale 1ns/1ps

module stat_host import stat_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_req_valid,  // ignored while busy
  input  host_req_t        i_req,
  input  logic             i_rd_gnt,
  input  logic             i_wr_gnt,
  input  logic [CNT_W-1:0] i_rd_data,
  input  logic             i_cerr,
  input  logic             i_uerr,
  input  rd_owner_e        i_rsp_owner,
  output mem_rd_t          o_rd,
  output mem_wr_t          o_wr,
  output logic             o_busy,
  output logic             o_rsp_valid,
  output host_rsp_t        o_rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,   // asking for a port until granted
    ST_WAIT,  // read in flight
    ST_RSP    // one cycle response pulse
  } state_e;

  state_e    state_q;
  state_e    state_d;
  host_req_t req_q;   // request held until the response
  logic      is_rd;
  logic      own_rsp;

  assign is_rd = (req_q.op == HOST_READ);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && i_req_valid) req_q <= i_req;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: if (i_req_valid) state_d = ST_REQ;
      ST_REQ: begin
        if (is_rd && i_rd_gnt) begin
          state_d = ST_WAIT;
        end else if (!is_rd && i_wr_gnt) begin
          state_d = ST_RSP;   // clear is done once written
        end
      end
      ST_WAIT: state_d = ST_RSP; // one wait cycle covers RD_LAT of 2
      ST_RSP:  state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // retry each cycle, the arbiter decides
  assign o_rd.en   = (state_q == ST_REQ) && is_rd;
  assign o_rd.addr = req_q.idx;
  assign o_wr.en   = (state_q == ST_REQ) && !is_rd;
  assign o_wr.addr = req_q.idx;
  assign o_wr.data = '0;
  assign o_wr.flip = req_q.flip;

  assign o_busy      = (state_q != ST_IDLE);
  assign o_rsp_valid = (state_q == ST_RSP);

  assign own_rsp    = (state_q == ST_RSP) && is_rd && (i_rsp_owner == OWN_HOST);
  assign o_rsp.data = own_rsp ? i_rd_data : '0; // clear answers with zero
  assign o_rsp.cerr = own_rsp && i_cerr;
  assign o_rsp.uerr = own_rsp && i_uerr;

endmodule

// File: hdl/stat_update.sv
`timescale 1ns/1ps

// event read at t, data back and sum written at t+2
module stat_update import stat_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             i_evt_valid,
  input  evt_t             i_evt,
  input  logic [CNT_W-1:0] i_rd_data,   // forwarded read data
  input  logic             i_uerr,
  input  rd_owner_e        i_rsp_owner,
  output mem_rd_t          o_rd,
  output mem_wr_t          o_wr,
  output logic             o_evt_uerr,
  output logic [IDX_W-1:0] o_evt_uerr_idx
);

  logic             s1_valid;
  logic             s2_valid;
  evt_t             s1_evt;
  evt_t             s2_evt;
  logic             own_rsp;  // returning data belongs to stage 2
  logic             bad_rd;   // stored counter lost
  logic [CNT_W:0]   sum;      // one extra bit for the carry
  logic [CNT_W-1:0] inc_ext;
  logic [CNT_W-1:0] new_cnt;

  // every event reads at once, the arbiter never refuses the engine
  assign o_rd.en   = i_evt_valid;
  assign o_rd.addr = i_evt.idx;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= i_evt_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_evt <= i_evt;
    s2_evt <= s1_evt;
  end

  assign own_rsp = s2_valid && (i_rsp_owner == OWN_ENGINE);
  assign bad_rd  = own_rsp && i_uerr;
  assign inc_ext = {{(CNT_W-INC_W){1'b0}}, s2_evt.inc};
  assign sum     = {1'b0, i_rd_data} + {1'b0, inc_ext};

  always_comb begin
    if (bad_rd) begin
      new_cnt = inc_ext;          // restart from this event alone
    end else if (sum[CNT_W]) begin
      new_cnt = cnt_max;          // saturate
    end else begin
      new_cnt = sum[CNT_W-1:0];
    end
  end

  assign o_wr.en   = s2_valid;
  assign o_wr.addr = s2_evt.idx;
  assign o_wr.data = new_cnt;
  assign o_wr.flip = '0;          // injection is a host feature only

  assign o_evt_uerr     = bad_rd;
  assign o_evt_uerr_idx = s2_evt.idx;

  a_rsp_is_engine: assert property (@(posedge clk) disable iff (!rst_n)
    s2_valid |-> (i_rsp_owner == OWN_ENGINE));

endmodule

// File: hdl/stat_arbiter.sv
`timescale 1ns/1ps

module stat_arbiter import stat_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  mem_rd_t   i_eng_rd,
  input  mem_wr_t   i_eng_wr,
  input  mem_rd_t   i_host_rd,
  input  mem_wr_t   i_host_wr,
  output logic      o_host_rd_gnt,
  output logic      o_host_wr_gnt,
  output mem_rd_t   o_mem_rd,
  output mem_wr_t   o_mem_wr,
  output rd_owner_e o_rsp_owner // owner of the data returning now
);

  rd_owner_e rd_owner; // owner of the read issued now
  logic      owner_q;

  // engine always wins and the host only fills idle slots
  assign o_host_rd_gnt = i_host_rd.en && !i_eng_rd.en;
  assign o_host_wr_gnt = i_host_wr.en && !i_eng_wr.en;

  always_comb begin
    o_mem_rd = '0; // idle port carries a clean address
    if (i_eng_rd.en) begin
      o_mem_rd = i_eng_rd;
    end else if (o_host_rd_gnt) begin
      o_mem_rd = i_host_rd;
    end
  end

  always_comb begin
    o_mem_wr = '0;
    if (i_eng_wr.en) begin
      o_mem_wr = i_eng_wr;
    end else if (o_host_wr_gnt) begin
      o_mem_wr = i_host_wr;
    end
  end

  assign rd_owner = i_eng_rd.en ? OWN_ENGINE : OWN_HOST;

  delay #(
    .WIDTH  (1),
    .STAGES (RD_LAT)
  ) u_owner_dly (
    .clk   (clk),
    .rst_n (rst_n),
    .i_in  (rd_owner),
    .o_out (owner_q)
  );

  assign o_rsp_owner = rd_owner_e'(owner_q);

  // the host holds one request, so it never asks for both ports at once
  a_host_one_port: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({i_host_rd.en, i_host_wr.en}));

endmodule

// File: hdl/stat_sram.sv
`timescale 1ns/1ps

module stat_sram import stat_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  mem_rd_t          i_rd,
  input  mem_wr_t          i_wr,
  output logic [CNT_W-1:0] o_rd_data, // valid RD_LAT after the read
  output logic             o_cerr,
  output logic             o_uerr
);

  logic [CW_W-1:0] mem [2**IDX_W]; // codeword array
  logic [CW_W-1:0] wr_cw;          // encoded write word after injection
  logic [CW_W-1:0] rd_cw1;         // array output
  logic [CW_W-1:0] rd_cw2;         // second read stage, feeds the decoder

  always_comb begin
    wr_cw = secded_enc(i_wr.data);
    // flip mask hits data bits only, parity stays as computed
    wr_cw[FLIP0_POS] = wr_cw[FLIP0_POS] ^ i_wr.flip[0];
    wr_cw[FLIP1_POS] = wr_cw[FLIP1_POS] ^ i_wr.flip[1];
  end

  always_ff @(posedge clk) begin
    if (i_wr.en) mem[i_wr.addr] <= wr_cw; // stored at the end of the write cycle
  end

  // read samples the array at the end of the issue cycle, so a write in the
  // same cycle is missed and left to the bypass
  always_ff @(posedge clk) begin
    if (i_rd.en) rd_cw1 <= mem[i_rd.addr];
    rd_cw2 <= rd_cw1;
  end

  always_comb begin
    o_rd_data = secded_dec(rd_cw2, o_cerr, o_uerr); // correct single, flag double
  end

  a_rd_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    i_rd.en |-> !$isunknown(i_rd.addr));

endmodule

// File: hdl/sram_bypass.sv
`timescale 1ns/1ps

// forwards writes the array has not seen yet onto the read data, so a
// read-modify-write loop sees its own recent writes
module sram_bypass #(
  parameter int WA               = 6,
  parameter int WD               = 32,
  parameter int READ_LATENCY     = 2,
  parameter bit UNFLOPPED_BYPASS = 0
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [WA-1:0] i_sra,   // read address issued this cycle
  input  logic [WD-1:0] i_srd,   // sram read data, READ_LATENCY later
  input  logic [WA-1:0] i_swa,
  input  logic          i_swen,
  input  logic [WD-1:0] i_swd,
  input  logic          i_suerr,
  input  logic          i_scerr,
  output logic [WD-1:0] o_rd,
  output logic          o_uerr,
  output logic          o_cerr
);

  logic [WA-1:0]         ra_q [1:READ_LATENCY]; // read address, index is age
  logic [WD-1:0]         wd_q [1:READ_LATENCY]; // write data, index is age
  logic [READ_LATENCY:1] hit;                   // write matches a read in flight
  logic [READ_LATENCY:1] hit_dly;               // hit lined up with its read data
  logic                  hit_now;               // write in the cycle the data returns

  // age the read addresses
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i <= READ_LATENCY; i++) ra_q[i] <= '0;
    end else begin
      ra_q[1] <= i_sra;
      for (int i = 2; i <= READ_LATENCY; i++) ra_q[i] <= ra_q[i-1];
    end
  end

  always_ff @(posedge clk) begin
    wd_q[1] <= i_swd;
    for (int i = 2; i <= READ_LATENCY; i++) wd_q[i] <= wd_q[i-1];
  end

  // hit[i] pairs the current write with the read issued READ_LATENCY-i ago,
  // then waits i cycles for that read to come back
  for (genvar i = 1; i <= READ_LATENCY; i++) begin : g_cmp
    if (i == READ_LATENCY) begin : g_cur
      assign hit[i] = i_swen && (i_swa == i_sra); // read and write same cycle
    end else begin : g_old
      assign hit[i] = i_swen && (i_swa == ra_q[READ_LATENCY-i]);
    end
    delay #(
      .WIDTH  (1),
      .STAGES (i)
    ) u_hit_dly (
      .clk   (clk),
      .rst_n (rst_n),
      .i_in  (hit[i]),
      .o_out (hit_dly[i])
    );
  end

  assign hit_now = i_swen && (i_swa == ra_q[READ_LATENCY]);

  always_comb begin
    o_rd   = i_srd;   // sram data unless a write overrides it
    o_uerr = i_suerr;
    o_cerr = i_scerr;
    for (int i = READ_LATENCY; i >= 1; i--) begin // oldest first, newest lands last
      if (hit_dly[i]) begin
        o_rd   = wd_q[i];
        o_uerr = 1'b0;  // forwarded data never went through the array
        o_cerr = 1'b0;
      end
    end
    if (UNFLOPPED_BYPASS && hit_now) begin
      o_rd   = i_swd;   // long combinational path, off by default
      o_uerr = 1'b0;
      o_cerr = 1'b0;
    end
  end

  a_swen_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(i_swen));

endmodule

// File: hdl/delay.sv
`timescale 1ns/1ps

module delay #(
  parameter int WIDTH  = 1,
  parameter int STAGES = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] i_in,
  output logic [WIDTH-1:0] o_out
);

  logic [WIDTH-1:0] stage_q [STAGES]; // stage 0 is the newest

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < STAGES; i++) stage_q[i] <= '0;
    end else begin
      stage_q[0] <= i_in;
      for (int i = 1; i < STAGES; i++) stage_q[i] <= stage_q[i-1]; // shift one step
    end
  end

  assign o_out = stage_q[STAGES-1];

endmodule

// File: hdl/stat_pkg.sv
package stat_pkg;

  localparam int IDX_W  = 6;             // 64 counters
  localparam int CNT_W  = 16;            // counter width
  localparam int INC_W  = 4;             // event increment width
  localparam int RD_LAT = 2;             // sram read latency in cycles
  localparam int CHK_W  = 6;             // 5 hamming bits plus overall parity
  localparam int CW_W   = CNT_W + CHK_W; // stored codeword width
  localparam int FLIP_W = 2;             // injectable data bits on a host clear

  localparam int FLIP0_POS = 3;          // codeword position of data bit 0
  localparam int FLIP1_POS = 5;          // codeword position of data bit 1

  localparam logic [CNT_W-1:0] cnt_max = '1; // saturation value

  typedef struct packed {
    logic [IDX_W-1:0] idx;
    logic [INC_W-1:0] inc;
  } evt_t;

  typedef enum logic {
    HOST_READ,
    HOST_CLEAR
  } host_op_e;

  typedef struct packed {
    host_op_e          op;
    logic [IDX_W-1:0]  idx;
    logic [FLIP_W-1:0] flip; // per bit, invert stored data bit on a clear
  } host_req_t;

  typedef struct packed {
    logic [CNT_W-1:0] data;
    logic             cerr;
    logic             uerr;
  } host_rsp_t;

  typedef struct packed {
    logic             en;
    logic [IDX_W-1:0] addr;
  } mem_rd_t;

  typedef struct packed {
    logic              en;
    logic [IDX_W-1:0]  addr;
    logic [CNT_W-1:0]  data;
    logic [FLIP_W-1:0] flip;
  } mem_wr_t;

  typedef enum logic {
    OWN_ENGINE,
    OWN_HOST
  } rd_owner_e;

  // hamming layout, positions 1..21, parity at powers of two, overall parity at 0
  function automatic logic [CW_W-1:0] secded_enc(input logic [CNT_W-1:0] data);
    logic [CW_W-1:0] cw;
    int              d;
    cw = '0;
    d  = 0;
    for (int p = 1; p < CW_W; p++) begin
      if ((p & (p - 1)) != 0) begin // not a power of two so a data slot
        cw[p] = data[d];
        d++;
      end
    end
    for (int k = 0; k < CHK_W - 1; k++) begin
      for (int p = 1; p < CW_W; p++) begin
        if ((p & (1 << k)) != 0) cw[1 << k] = cw[1 << k] ^ cw[p]; // own slot still 0
      end
    end
    cw[0] = ^cw[CW_W-1:1]; // overall parity for double detect
    return cw;
  endfunction

  function automatic logic [CNT_W-1:0] secded_dec(input  logic [CW_W-1:0] cw,
                                                  output logic            cerr,
                                                  output logic            uerr);
    logic [CW_W-1:0]    fix;
    logic [CHK_W-2:0]   syn;
    logic               odd;
    logic [CNT_W-1:0]   data;
    int                 d;
    syn  = '0;
    fix  = cw;
    cerr = 1'b0;
    uerr = 1'b0;
    data = '0;
    d    = 0;
    for (int k = 0; k < CHK_W - 1; k++) begin
      for (int p = 1; p < CW_W; p++) begin
        if ((p & (1 << k)) != 0) syn[k] = syn[k] ^ cw[p];
      end
    end
    odd = ^cw;
    if (odd) begin                  // odd flip count, take it as one
      if (syn < CW_W) begin
        fix[syn] = ~fix[syn];       // syn 0 points at the overall bit
        cerr     = 1'b1;
      end else begin
        uerr = 1'b1;                // syndrome outside the word
      end
    end else if (syn != '0) begin
      uerr = 1'b1;                  // even flips, not correctable
    end
    for (int p = 1; p < CW_W; p++) begin
      if ((p & (p - 1)) != 0) begin
        data[d] = fix[p];
        d++;
      end
    end
    return data;
  endfunction

endpackage
